//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;

    localparam int imem_depth_log2 = 8;  // 256 instruction words
    localparam int dmem_depth_log2 = 8;  // 256 data words

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [imem_depth_log2-1:0] imem_addr_t;

    // RV32I major opcodes of the supported subset
    localparam logic [6:0] op_reg    = 7'b011_0011;
    localparam logic [6:0] op_imm    = 7'b001_0011;
    localparam logic [6:0] op_load   = 7'b000_0011;
    localparam logic [6:0] op_store  = 7'b010_0011;
    localparam logic [6:0] op_branch = 7'b110_0011;
    localparam logic [6:0] op_jal    = 7'b110_1111;

    localparam word_t nop_instr = 32'h0000_0013;  // addi x0, x0, 0

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

endpackage

`default_nettype wire

//--- hdl/pipe_if.sv
`default_nettype none

// Decode to execute bundle
interface de_ex_if;
    import cpu_pkg::*;

    logic      valid;
    word_t     pc;
    word_t     rs1_value;
    word_t     rs2_value;
    word_t     imm;
    logic      alu_src;    // 1 selects the immediate
    alu_op_t   alu_op;
    logic      is_branch;
    logic      branch_ne;  // bne rather than beq
    logic      is_jump;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    reg_addr_t rd;

    modport src (
        output valid, pc, rs1_value, rs2_value, imm, alu_src, alu_op,
               is_branch, branch_ne, is_jump, mem_read, mem_write, reg_write, rd
    );
    modport dst (
        input valid, pc, rs1_value, rs2_value, imm, alu_src, alu_op,
              is_branch, branch_ne, is_jump, mem_read, mem_write, reg_write, rd
    );
endinterface

// Execute to memory bundle
interface ex_mem_if;
    import cpu_pkg::*;

    logic      valid;
    word_t     result;      // ALU result, also the memory address
    word_t     store_data;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    reg_addr_t rd;

    modport src (output valid, result, store_data, mem_read, mem_write, reg_write, rd);
    modport dst (input valid, result, store_data, mem_read, mem_write, reg_write, rd);
endinterface

// Memory to writeback bundle
interface mem_wb_if;
    import cpu_pkg::*;

    logic      valid;
    logic      reg_write;
    reg_addr_t rd;
    word_t     wb_data;

    modport src (output valid, reg_write, rd, wb_data);
    modport dst (input valid, reg_write, rd, wb_data);
endinterface

`default_nettype wire

//--- hdl/fetch.sv
`default_nettype none

module fetch (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               enable,
    input  logic               prog_we,
    input  cpu_pkg::imem_addr_t prog_addr,
    input  cpu_pkg::word_t     prog_data,
    input  logic               redirect,
    input  cpu_pkg::word_t     redirect_target,
    output logic               if_valid,
    output cpu_pkg::word_t     if_pc,
    output cpu_pkg::word_t     if_instr
);
    import cpu_pkg::*;

    word_t      imem [2**imem_depth_log2];
    word_t      pc;
    imem_addr_t pc_index;

    assign pc_index = pc[imem_depth_log2+1:2];  // Word index

    // Program load port, independent of enable
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= '0;
            if_valid <= 1'b0;
            if_instr <= nop_instr;
            if_pc    <= '0;
        end else if (enable) begin
            if (redirect) begin
                pc       <= redirect_target;
                if_valid <= 1'b0;      // Wrong-path fetch dropped
                if_instr <= nop_instr;
            end else begin
                pc       <= pc + 32'd4;
                if_valid <= 1'b1;
                if_instr <= imem[pc_index];
            end
            if_pc <= pc;
        end
    end

    // Targets come from execute; a misaligned one would fetch garbage
    a_target_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |-> redirect_target[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/decode.sv
`default_nettype none

module decode (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              enable,
    input  logic              flush,
    input  logic              if_valid,
    input  cpu_pkg::word_t    if_pc,
    input  cpu_pkg::word_t    if_instr,
    output cpu_pkg::reg_addr_t rs1_addr,
    output cpu_pkg::reg_addr_t rs2_addr,
    input  cpu_pkg::word_t    rs1_value,
    input  cpu_pkg::word_t    rs2_value,
    de_ex_if.src              de_ex
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    word_t      imm_i, imm_s, imm_b, imm_j;
    word_t      imm;
    logic       legal;
    logic       keep;  // Entry survives into execute
    logic       alu_src, is_branch, is_jump, mem_read, mem_write, reg_write;
    alu_op_t    alu_op;

    assign opcode   = if_instr[6:0];
    assign rd       = if_instr[11:7];
    assign funct3   = if_instr[14:12];
    assign rs1_addr = if_instr[19:15];
    assign rs2_addr = if_instr[24:20];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                    if_instr[20], if_instr[30:21], 1'b0};

    always_comb begin
        legal     = 1'b1;
        imm       = imm_i;
        alu_src   = 1'b0;
        alu_op    = alu_add;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            op_reg: begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = if_instr[30] ? alu_sub : alu_add;  // funct7 bit 5
                    3'b111:  alu_op = alu_and;
                    3'b110:  alu_op = alu_or;
                    3'b100:  alu_op = alu_xor;
                    3'b010:  alu_op = alu_slt;
                    default: legal  = 1'b0;
                endcase
            end
            op_imm: begin  // addi only
                legal     = (funct3 == 3'b000);
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            op_load: begin
                legal     = (funct3 == 3'b010);
                alu_src   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            op_store: begin
                legal     = (funct3 == 3'b010);
                imm       = imm_s;
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            op_branch: begin
                legal     = (funct3[2:1] == 2'b00);  // beq, bne
                imm       = imm_b;
                is_branch = 1'b1;
            end
            op_jal: begin
                imm     = imm_j;
                is_jump = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    assign keep = if_valid && legal && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_ex.valid     <= 1'b0;
            de_ex.is_branch <= 1'b0;
            de_ex.is_jump   <= 1'b0;
            de_ex.mem_read  <= 1'b0;
            de_ex.mem_write <= 1'b0;
            de_ex.reg_write <= 1'b0;
        end else if (enable) begin
            de_ex.valid     <= keep;
            de_ex.is_branch <= keep && is_branch;
            de_ex.is_jump   <= keep && is_jump;
            de_ex.mem_read  <= keep && mem_read;
            de_ex.mem_write <= keep && mem_write;
            de_ex.reg_write <= keep && reg_write && (rd != '0);  // x0 writes dropped
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            de_ex.pc        <= if_pc;
            de_ex.rs1_value <= rs1_value;
            de_ex.rs2_value <= rs2_value;
            de_ex.imm       <= imm;
            de_ex.alu_src   <= alu_src;
            de_ex.alu_op    <= alu_op;
            de_ex.branch_ne <= funct3[0];
            de_ex.rd        <= rd;
        end
    end

endmodule

`default_nettype wire

//--- hdl/register_bank.sv
`default_nettype none

module register_bank (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               write_enable,
    input  cpu_pkg::reg_addr_t write_address,
    input  cpu_pkg::word_t     write_value,
    input  cpu_pkg::reg_addr_t read_address1,
    input  cpu_pkg::reg_addr_t read_address2,
    output cpu_pkg::word_t     value1,
    output cpu_pkg::word_t     value2
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_address != '0) begin
            regs[write_address] <= write_value;
        end
    end

    // Write-first bypass, x0 stays zero
    always_comb begin
        value1 = regs[read_address1];
        value2 = regs[read_address2];
        if (write_enable && write_address == read_address1) value1 = write_value;
        if (write_enable && write_address == read_address2) value2 = write_value;
        if (read_address1 == '0) value1 = '0;
        if (read_address2 == '0) value2 = '0;
    end

endmodule

`default_nettype wire

//--- hdl/execute.sv
`default_nettype none

module execute (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           enable,
    de_ex_if.dst           de_ex,
    ex_mem_if.src          ex_mem,
    output logic           redirect,
    output cpu_pkg::word_t redirect_target
);
    import cpu_pkg::*;

    word_t op_a, op_b;
    word_t alu_result;
    logic  signed_lt;
    logic  operands_equal;
    logic  branch_taken;

    assign op_a = de_ex.rs1_value;
    assign op_b = de_ex.alu_src ? de_ex.imm : de_ex.rs2_value;

    assign signed_lt = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (de_ex.alu_op)
            alu_add: alu_result = op_a + op_b;
            alu_sub: alu_result = op_a - op_b;
            alu_and: alu_result = op_a & op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_xor: alu_result = op_a ^ op_b;
            alu_slt: alu_result = {{(xlen-1){1'b0}}, signed_lt};
            default: alu_result = '0;
        endcase
    end

    // Branch compare on the raw register values
    assign operands_equal = (de_ex.rs1_value == de_ex.rs2_value);
    assign branch_taken   = de_ex.is_branch && (operands_equal ^ de_ex.branch_ne);

    // Control bits arrive already cleared for bubbles
    assign redirect        = branch_taken || de_ex.is_jump;
    assign redirect_target = de_ex.pc + de_ex.imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
            ex_mem.reg_write <= 1'b0;
        end else if (enable) begin
            ex_mem.valid     <= de_ex.valid;
            ex_mem.mem_read  <= de_ex.mem_read;
            ex_mem.mem_write <= de_ex.mem_write;
            ex_mem.reg_write <= de_ex.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            ex_mem.result     <= alu_result;
            ex_mem.store_data <= de_ex.rs2_value;
            ex_mem.rd         <= de_ex.rd;
        end
    end

    // Decode must strip control from flushed and illegal slots
    a_redirect_valid: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |-> de_ex.valid);

endmodule

`default_nettype wire

//--- hdl/memory.sv
`default_nettype none

module memory (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           enable,
    ex_mem_if.dst          ex_mem,
    mem_wb_if.src          mem_wb,
    output logic           store_valid,
    output cpu_pkg::word_t store_addr,
    output cpu_pkg::word_t store_data
);
    import cpu_pkg::*;

    word_t                      dmem [2**dmem_depth_log2];
    logic [dmem_depth_log2-1:0] dmem_index;
    word_t                      load_data;

    assign dmem_index = ex_mem.result[dmem_depth_log2+1:2];
    assign load_data  = dmem[dmem_index];  // Asynchronous read

    assign store_valid = enable && ex_mem.valid && ex_mem.mem_write;
    assign store_addr  = ex_mem.result;
    assign store_data  = ex_mem.store_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**dmem_depth_log2; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_valid) begin
            dmem[dmem_index] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb.valid     <= 1'b0;
            mem_wb.reg_write <= 1'b0;
        end else if (enable) begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.reg_write;
        end
    end

    // Writeback select folded into the register
    always_ff @(posedge clk) begin
        if (enable) begin
            mem_wb.rd      <= ex_mem.rd;
            mem_wb.wb_data <= ex_mem.mem_read ? load_data : ex_mem.result;
        end
    end

    a_mem_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write)
            |-> ex_mem.result[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/cpu.sv
`default_nettype none

module cpu (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                enable,
    input  logic                prog_we,
    input  cpu_pkg::imem_addr_t prog_addr,
    input  cpu_pkg::word_t      prog_data,
    output logic                retire_valid,
    output cpu_pkg::reg_addr_t  retire_rd,
    output cpu_pkg::word_t      retire_data,
    output logic                store_valid,
    output cpu_pkg::word_t      store_addr,
    output cpu_pkg::word_t      store_data
);
    import cpu_pkg::*;

    logic      if_valid;
    word_t     if_pc, if_instr;
    reg_addr_t rs1_addr, rs2_addr;
    word_t     rs1_value, rs2_value;
    logic      redirect;
    word_t     redirect_target;

    de_ex_if  de_ex ();
    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();

    // Writeback: the retiring write, held off while disabled
    assign retire_valid = enable && mem_wb.valid && mem_wb.reg_write;
    assign retire_rd    = mem_wb.rd;
    assign retire_data  = mem_wb.wb_data;

    fetch u_fetch (
        .clk             (clk),
        .arst_n          (arst_n),
        .enable          (enable),
        .prog_we         (prog_we),
        .prog_addr       (prog_addr),
        .prog_data       (prog_data),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .if_valid        (if_valid),
        .if_pc           (if_pc),
        .if_instr        (if_instr)
    );

    decode u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .enable    (enable),
        .flush     (redirect),  // Same strobe that steers fetch
        .if_valid  (if_valid),
        .if_pc     (if_pc),
        .if_instr  (if_instr),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .de_ex     (de_ex.src)
    );

    register_bank u_register_bank (
        .clk           (clk),
        .arst_n        (arst_n),
        .write_enable  (retire_valid),
        .write_address (mem_wb.rd),
        .write_value   (mem_wb.wb_data),
        .read_address1 (rs1_addr),
        .read_address2 (rs2_addr),
        .value1        (rs1_value),
        .value2        (rs2_value)
    );

    execute u_execute (
        .clk             (clk),
        .arst_n          (arst_n),
        .enable          (enable),
        .de_ex           (de_ex.dst),
        .ex_mem          (ex_mem.src),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    memory u_memory (
        .clk         (clk),
        .arst_n      (arst_n),
        .enable      (enable),
        .ex_mem      (ex_mem.dst),
        .mem_wb      (mem_wb.src),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

endmodule

`default_nettype wire

//--- tb/tb_cpu.sv
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    logic       clk;
    logic       arst_n;
    logic       enable;
    logic       prog_we;
    imem_addr_t prog_addr;
    word_t      prog_data;
    logic       retire_valid;
    reg_addr_t  retire_rd;
    word_t      retire_data;
    logic       store_valid;
    word_t      store_addr;
    word_t      store_data;

    // Golden program and expected event streams
    word_t     prog_words [$];
    reg_addr_t exp_rd [$];
    word_t     exp_rdata [$];
    word_t     exp_saddr [$];
    word_t     exp_sdata [$];

    int retire_idx;
    int store_idx;
    int cycle_count;
    int cycle_limit;

    cpu DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .enable       (enable),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // Line kind in column 0 and hex fields after it
    task automatic load_golden();
        int    fd;
        int    n;
        int    count;
        byte   kind;
        string line;
        string rest;
        word_t w0, w1, w2, w3;
        fd = $fopen("tb/cpu_golden.txt", "r");
        if (fd == 0) begin
            abort_run("could not open tb/cpu_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1) begin
                    kind  = line.getc(0);
                    rest  = line.substr(1, line.len() - 1);
                    count = $sscanf(rest, "%h %h %h %h", w0, w1, w2, w3);
                    case (kind)
                        "P": begin
                            if (count > 0) prog_words.push_back(w0);
                            if (count > 1) prog_words.push_back(w1);
                            if (count > 2) prog_words.push_back(w2);
                            if (count > 3) prog_words.push_back(w3);
                        end
                        "R": begin
                            exp_rd.push_back(w0[4:0]);
                            exp_rdata.push_back(w1);
                        end
                        "S": begin
                            exp_saddr.push_back(w0);
                            exp_sdata.push_back(w1);
                        end
                        default: ;  // Comment or blank line
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // Strobes checked in order against the expected streams
    always @(negedge clk) begin
        if (!enable && (retire_valid === 1'b1 || store_valid === 1'b1)) begin
            abort_run("a strobe fired while enable was low");
        end else begin
            if (retire_valid === 1'b1) begin
                if (retire_idx >= exp_rd.size()) begin
                    abort_run("retire strobe after the last expected retire event");
                end else begin
                    check_value("retire_rd", word_t'(retire_rd), word_t'(exp_rd[retire_idx]));
                    check_value("retire_data", retire_data, exp_rdata[retire_idx]);
                    retire_idx++;
                end
            end
            if (store_valid === 1'b1) begin
                if (store_idx >= exp_saddr.size()) begin
                    abort_run("store strobe after the last expected store event");
                end else begin
                    check_value("store_addr", store_addr, exp_saddr[store_idx]);
                    check_value("store_data", store_data, exp_sdata[store_idx]);
                    store_idx++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            abort_run($sformatf("timeout: expected events still missing after %0d cycles",
                                cycle_count));
        end
    end

    initial begin
        int pause_cycles;
        int idle_cycles;
        void'($urandom(32'h60c6_a877));
        arst_n      = 1'b0;
        enable      = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        retire_idx  = 0;
        store_idx   = 0;
        cycle_count = 0;
        load_golden();
        cycle_limit = 16 + 8 * prog_words.size() + 100;

        repeat (16) @(posedge clk);
        foreach (prog_words[i]) begin  // Program load while still in reset
            prog_we   <= 1'b1;
            prog_addr <= imem_addr_t'(i);
            prog_data <= prog_words[i];
            @(posedge clk);
        end
        prog_we <= 1'b0;
        arst_n  <= 1'b1;
        enable  <= 1'b1;

        // Freeze the pipeline mid-stream after half of the retires
        while (retire_idx < exp_rd.size() / 2) @(posedge clk);
        pause_cycles = $urandom_range(20, 5);
        enable <= 1'b0;
        repeat (pause_cycles) @(posedge clk);
        enable <= 1'b1;

        while (retire_idx < exp_rd.size() || store_idx < exp_saddr.size()) @(posedge clk);
        idle_cycles = $urandom_range(12, 4);  // Core spins on its final jal
        repeat (idle_cycles) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/cpu_pkg.sv
hdl/pipe_if.sv
hdl/fetch.sv
hdl/decode.sv
hdl/register_bank.sv
hdl/execute.sv
hdl/memory.sv
hdl/cpu.sv
tb/tb_cpu.sv

//--- Makefile
# Verilator flow for the pipelined RV32I subset core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module tb_cpu

obj_dir/Vtb_cpu: verilog.f hdl/*.sv tb/tb_cpu.sv
	verilator --binary --timing --assert -f verilog.f --top-module tb_cpu

# The testbench reads tb/cpu_golden.txt, so it runs from the project root
sim: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/cpu_golden.txt
# P: program words in address order, up to four per line, hex
# R: expected retire, rd then data; S: expected store, address then data
P 00500093 ffd00113 00c00193 00700013   # 0x00 operand setup, write to x0
P 00208233 402082b3 0030f333 0030e3b3   # 0x10 add sub and or
P 0030c433 001124b3 0020a533 00302823   # 0x20 xor, slt both ways, sw
P 00202a23 00000013 00000013 01002583   # 0x30 sw, lw
P 01402603 005246b3 00108663 00100713   # 0x40 lw, xor, beq taken
P 00200713 00209663 00100793 00200793   # 0x50 bne taken
P 00208463 00109463 00c0006f 00100993   # 0x60 branches fall through, jal +12
P 00200993 06460813 00c588b3 00000013   # 0x70 addi, add from loaded values
P 00000013 01002c23 41088933 0000006f   # 0x80 sw, sub, jal to itself
R 01 00000005
R 02 fffffffd
R 03 0000000c
R 04 00000002
R 05 00000008
R 06 00000004
R 07 0000000d
R 08 00000009
R 09 00000001
R 0a 00000000
R 0b 0000000c
R 0c fffffffd
R 0d 0000000a
R 10 00000061
R 11 00000009
R 12 ffffffa8
S 00000010 0000000c
S 00000014 fffffffd
S 00000018 00000061
